// File: verilog.f
hdl/spi_flash_pkg.sv
hdl/bus_decode.sv
hdl/spi_regs.sv
hdl/spi_shifter.sv
hdl/spi_flash_ctrl.sv
dv/flash_model.sv
dv/tb_spi_flash_ctrl.sv

// File: Makefile
# Verilator flow for the SPI flash controller.

VERILATOR ?= verilator
TOP       ?= tb_spi_flash_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "No result line found in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_spi_flash_ctrl.sv
`timescale 1ns/1ps

module tb_spi_flash_ctrl
    import spi_flash_pkg::*;
();

    localparam int          half      = 2;
    localparam int          period    = 2 * half;
    localparam int          n_txn     = 16 + 8 + 3;          // Flash commands over all tests.
    localparam int          wd_cycles = n_txn * 128 + 1500;
    localparam logic [7:0]  base      = 8'h70;
    localparam logic [31:0] jedec_id  = 32'hEF4018C3;

    logic        ck;
    logic        rst_n;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    spi_pins_t   pins;
    logic        miso;
    logic [7:0]  fm_op;
    logic [23:0] fm_adr;
    int          fm_bits;

    logic [15:0] lfsr;
    logic [23:0] exp_addr;
    logic [31:0] exp_rdata;
    int          errors     = 0;
    int          test_errs  = 0;
    int          n_tests    = 0;
    int          n_failed   = 0;
    int          cs_cnt     = 0;
    int          cs_len     = 0;     // Length of the last cs low window.
    int          cs_windows = 0;

    spi_flash_ctrl #(
        .base_addr (base)
    ) i_dut (
        .ck      (ck),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .pins    (pins),
        .miso    (miso)
    );

    flash_model i_flash (
        .pins   (pins),
        .miso   (miso),
        .op     (fm_op),
        .adr    (fm_adr),
        .n_bits (fm_bits)
    );

    initial ck = 1'b0;
    always #(half) ck = ~ck;

    always @(negedge ck) begin
        if (rst_n && !pins.cs) begin
            cs_cnt <= cs_cnt + 1;
        end else if (cs_cnt != 0) begin
            cs_len     <= cs_cnt;
            cs_windows <= cs_windows + 1;
            cs_cnt     <= 0;
        end
    end

    initial begin
        #(wd_cycles * period);
        $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] reg_adr(input logic [1:0] off);
        return {base, 20'b0, off, 2'b00};
    endfunction

    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[7:0] ^ 8'hA5;
    endfunction

    // Expected read word for an opcode at address a.
    function automatic logic [31:0] exp_word(input logic [7:0] code, input logic [23:0] a);
        if (code == 8'h03) begin
            return {mem_byte(a), mem_byte(a + 24'd1), mem_byte(a + 24'd2), mem_byte(a + 24'd3)};
        end
        if (code == 8'h9F) return jedec_id;
        return 32'hFFFF_FFFF;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAIL %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors == test_errs) begin
            $display("%s: pass", name);
        end else begin
            n_failed++;
            $display("%s: %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // Called 1 ns after a rising edge; returns at the same point.
    task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat, input logic we,
                              output logic [31:0] rdt);
        int waited;
        waited      = 0;
        bus_req.adr = adr;
        bus_req.dat = dat;
        bus_req.we  = we;
        bus_req.cyc = 1'b1;
        do begin
            @(posedge ck);
            #1;
            waited++;
        end while (!bus_rsp.ack);
        if (waited != 1) report_error("ack did not follow the request by one cycle");
        rdt = bus_rsp.rdt;
        @(posedge ck);
        #1;
        if (bus_rsp.ack) report_error("ack lasted more than one cycle");
        bus_req.cyc = 1'b0;
        @(posedge ck);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(adr, dat, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdt);
        bus_access(adr, 32'h0, 1'b0, rdt);
    endtask

    task automatic poll_ready();
        logic [31:0] st;
        st = '0;
        while (!st[0]) begin
            bus_read(reg_adr(reg_addr_off), st);
        end
    endtask

    task automatic idle_gap();
        logic [31:0] g;
        rand_bits(3, g);
        repeat (g) begin
            @(posedge ck);
            #1;
        end
    endtask

    task automatic write_addr(input logic [23:0] a);
        bus_write(reg_adr(reg_addr_off), {8'h0, a});
        exp_addr = a;
    endtask

    // One flash command, checked on the pins, in the flash model and on the bus.
    task automatic run_cmd(input logic no_read, input logic incr, input logic tx,
                           input logic [7:0] code);
        int          exp_bits;
        int          win;
        logic [23:0] a;
        logic [31:0] rd;
        exp_bits = 8 + (tx ? 24 : 0) + (no_read ? 0 : 32);
        a        = exp_addr;
        win      = cs_windows;
        bus_write(reg_adr(reg_cmd_off), {21'b0, no_read, incr, tx, code});
        // bus_write returns one cycle into the transfer.
        if (cs_cnt != 1) report_error("cs did not fall in the cycle after the ack cycle");
        if (incr) exp_addr = exp_addr + 24'd4;
        if (!no_read) exp_rdata = exp_word(code, a);
        poll_ready();
        if (cs_windows != win + 1) report_error("expected exactly one cs low window");
        if (cs_len != 2 * exp_bits) report_mismatch("cs_low_cycles", 2 * exp_bits, cs_len);
        if (fm_bits != exp_bits) report_mismatch("fm_bits", exp_bits, fm_bits);
        if (fm_op !== code) report_mismatch("fm_op", {24'h0, code}, {24'h0, fm_op});
        if (tx && fm_adr !== a) report_mismatch("fm_adr", {8'h0, a}, {8'h0, fm_adr});
        bus_read(reg_adr(reg_cmd_off), rd);
        if (rd !== exp_rdata) report_mismatch("rdt", exp_rdata, rd);
    endtask

    // Holds an unclaimed access for ten cycles.
    task automatic bad_access(input logic [31:0] adr, input logic [31:0] dat, input logic we);
        bus_req.adr = adr;
        bus_req.dat = dat;
        bus_req.we  = we;
        bus_req.cyc = 1'b1;
        repeat (10) begin
            @(posedge ck);
            #1;
            if (bus_rsp.ack) report_error("unclaimed access was acknowledged");
            if (bus_rsp.rdt !== 32'h0) report_mismatch("rdt", 32'h0, bus_rsp.rdt);
            if (!pins.cs) report_error("unclaimed access started a flash transaction");
        end
        bus_req.cyc = 1'b0;
        @(posedge ck);
        #1;
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] f;
        logic [31:0] rd;
        logic [7:0]  bad;
        lfsr      = 16'd39;
        rst_n     = 1'b0;
        bus_req   = '0;
        exp_addr  = '0;
        exp_rdata = '0;
        repeat (5) @(posedge ck);
        #1;
        rst_n = 1'b1;

        if (pins.cs !== 1'b1) report_mismatch("pins.cs", 32'h1, {31'h0, pins.cs});
        if (pins.sck !== 1'b0) report_mismatch("pins.sck", 32'h0, {31'h0, pins.sck});
        if (pins.mosi !== 1'b1) report_mismatch("pins.mosi", 32'h1, {31'h0, pins.mosi});
        if (bus_rsp.ack !== 1'b0) report_error("ack is high after reset");
        bus_read(reg_adr(reg_addr_off), rd);
        if (rd !== 32'h1) report_mismatch("rdt", 32'h1, rd);
        bus_read(reg_adr(reg_cmd_off), rd);
        if (rd !== 32'h0) report_mismatch("rdt", 32'h0, rd);
        end_test("reset_status");

        repeat (16) begin
            rand_bits(24, v);
            rand_bits(1, f);
            write_addr(v[23:0]);
            run_cmd(1'b0, f[0], 1'b1, 8'h03);
            idle_gap();
        end
        end_test("random_reads");

        rand_bits(24, v);
        write_addr(v[23:0]);
        repeat (8) begin
            run_cmd(1'b0, 1'b1, 1'b1, 8'h03);   // Address steps by 4 each time.
            idle_gap();
        end
        end_test("auto_increment");

        run_cmd(1'b1, 1'b0, 1'b0, 8'h06);
        end_test("write_enable");

        run_cmd(1'b0, 1'b0, 1'b0, 8'h9F);
        end_test("read_id");

        rand_bits(8, v);
        bad = (v[7:0] == base) ? v[7:0] ^ 8'h01 : v[7:0];
        rand_bits(24, v);
        bad_access({bad, 20'b0, reg_addr_off, 2'b00}, 32'h0, 1'b0);
        bad_access({bad, 20'b0, reg_addr_off, 2'b00}, {8'h0, v[23:0]}, 1'b1);
        bad_access({bad, 20'b0, reg_cmd_off, 2'b00}, {21'b0, 3'b001, 8'h03}, 1'b1);
        bus_read(reg_adr(reg_addr_off), rd);
        if (rd !== 32'h1) report_mismatch("rdt", 32'h1, rd);
        run_cmd(1'b0, 1'b0, 1'b1, 8'h03);       // Address must be the old one.
        end_test("decode");

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: dv/flash_model.sv
`timescale 1ns/1ps

module flash_model
    import spi_flash_pkg::*;
(
    input  spi_pins_t   pins,
    output logic        miso,
    output logic [7:0]  op,
    output logic [23:0] adr,
    output int          n_bits
);

    localparam logic [31:0] jedec_id = 32'hEF4018C3;

    logic cs;
    logic sck;
    logic mosi;

    assign cs   = pins.cs;
    assign sck  = pins.sck;
    assign mosi = pins.mosi;

    initial begin
        miso   = 1'b1;
        op     = '0;
        adr    = '0;
        n_bits = 0;
    end

    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[7:0] ^ 8'hA5;
    endfunction

    function automatic logic has_addr(input logic [7:0] code);
        return code == 8'h03 || code == 8'h0B;
    endfunction

    // Bit driven back during transfer bit k.
    function automatic logic reply_bit(input int k);
        int         hdr;
        int         d;
        logic [7:0] byte_v;
        hdr = has_addr(op) ? 32 : 8;
        if (k < hdr) return 1'b1;
        d = k - hdr;
        if (op == 8'h03) begin
            byte_v = mem_byte(adr + 24'(d / 8));
            return byte_v[7 - (d % 8)];
        end
        if (op == 8'h9F && d < 32) return jedec_id[31 - d];
        return 1'b1;
    endfunction

    always @(posedge sck or negedge cs) begin
        if (!sck) begin                       // Chip select fell.
            n_bits = 0;
            op     = '0;
            adr    = '0;
            miso   = 1'b1;
        end else if (!cs) begin
            if (n_bits < 8) begin
                op = {op[6:0], mosi};
            end else if (has_addr(op) && n_bits < 32) begin
                adr = {adr[22:0], mosi};
            end
            miso   = reply_bit(n_bits);
            n_bits = n_bits + 1;
        end
    end

endmodule

// File: hdl/spi_flash_ctrl.sv
`timescale 1ns/1ps

module spi_flash_ctrl
    import spi_flash_pkg::*;
#(
    parameter logic [7:0] base_addr = 8'h70
) (
    input  logic      ck,
    input  logic      rst_n,
    input  bus_req_t  bus_req,
    output bus_rsp_t  bus_rsp,
    output spi_pins_t pins,
    input  logic      miso
);

    logic        sel;
    logic        start;
    spi_cmd_t    cmd;
    logic [23:0] addr;
    logic [31:0] rdata;
    logic        ready;

    bus_decode #(
        .base_addr (base_addr)
    ) i_bus_decode (
        .ck      (ck),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .sel     (sel),
        .ack     (bus_rsp.ack)
    );

    spi_regs i_spi_regs (
        .ck      (ck),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .sel     (sel),
        .rdata   (rdata),
        .ready   (ready),
        .rdt     (bus_rsp.rdt),
        .start   (start),
        .cmd     (cmd),
        .addr    (addr)
    );

    spi_shifter i_spi_shifter (
        .ck      (ck),
        .rst_n   (rst_n),
        .start   (start),
        .cmd     (cmd),
        .addr    (addr),
        .miso    (miso),
        .pins    (pins),
        .rdata   (rdata),
        .ready   (ready)
    );

endmodule

// File: hdl/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter
    import spi_flash_pkg::*;
(
    input  logic                 ck,
    input  logic                 rst_n,
    input  logic                 start,
    input  spi_cmd_t             cmd,
    input  logic [addr_bits-1:0] addr,
    input  logic                 miso,
    output spi_pins_t            pins,
    output logic [31:0]          rdata,
    output logic                 ready
);

    localparam int tx_bits = op_bits + addr_bits;
    localparam int cnt_w   = $clog2(tx_bits + data_bits + 1);

    logic [cnt_w-1:0]     bit_cnt;
    logic [cnt_w-1:0]     load_cnt;
    logic                 phase;
    logic                 busy;
    logic                 bit_done;
    logic                 reading;
    logic [tx_bits-1:0]   tx;
    logic [data_bits-1:0] rx;

    assign busy     = bit_cnt != '0;
    assign bit_done = busy && phase;  // Last ck of sck high.

    assign load_cnt = cnt_w'(op_bits)
                    + (cmd.tx_addr ? cnt_w'(addr_bits) : cnt_w'(0))
                    + (cmd.no_read ? cnt_w'(0) : cnt_w'(data_bits));

    // A new start aborts whatever is in flight.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            phase   <= 1'b0;
        end else if (start) begin
            bit_cnt <= load_cnt;
            phase   <= 1'b0;
        end else if (busy) begin
            phase <= ~phase;
            if (phase) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // Opcode then address, MSB first.
    always_ff @(posedge ck) begin
        if (start) begin
            tx      <= {cmd.code, (cmd.tx_addr ? addr : {addr_bits{1'b0}})};
            reading <= !cmd.no_read;
        end else if (bit_done) begin
            tx <= {tx[tx_bits-2:0], 1'b0};
            rx <= {rx[data_bits-2:0], miso};
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (!start && bit_done && reading && bit_cnt == cnt_w'(1)) begin
            rdata <= {rx[data_bits-2:0], miso};   // First bit in ends at 31.
        end
    end

    assign pins.cs   = !busy;
    assign pins.sck  = busy && phase;
    assign pins.mosi = busy ? tx[tx_bits-1] : 1'b1;  // Idles high.
    assign ready     = !busy;

endmodule

// File: hdl/spi_regs.sv
`timescale 1ns/1ps

module spi_regs
    import spi_flash_pkg::*;
(
    input  logic        ck,
    input  logic        rst_n,
    input  bus_req_t    bus_req,
    input  logic        sel,
    input  logic [31:0] rdata,
    input  logic        ready,
    output logic [31:0] rdt,
    output logic        start,
    output spi_cmd_t    cmd,
    output logic [23:0] addr
);

    logic [1:0] off;
    logic       wr_cmd;
    logic       wr_addr;
    logic       rd_any;

    assign off     = bus_req.adr[3:2];
    assign wr_cmd  = sel && bus_req.we && (off == reg_cmd_off);
    assign wr_addr = sel && bus_req.we && (off == reg_addr_off);
    assign rd_any  = sel && !bus_req.we;

    // Strobe lands in the ack cycle, with the new command.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= wr_cmd;
        end
    end

    always_ff @(posedge ck) begin
        if (wr_cmd) begin
            cmd <= spi_cmd_t'(bus_req.dat[$bits(spi_cmd_t)-1:0]);
        end
    end

    // The shifter takes the old address on start; step it afterwards.
    always_ff @(posedge ck) begin
        if (wr_addr) begin
            addr <= bus_req.dat[23:0];
        end else if (start && cmd.incr_addr) begin
            addr <= addr + 24'd4;
        end
    end

    // Read data is only driven in the ack cycle.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            rdt <= '0;
        end else if (rd_any) begin
            if (off == reg_cmd_off) begin
                rdt <= rdata;                // Data word shares offset 0.
            end else begin
                rdt <= {31'b0, ready};       // Status at any other offset.
            end
        end else begin
            rdt <= '0;
        end
    end

endmodule

// File: hdl/bus_decode.sv
`timescale 1ns/1ps

module bus_decode
    import spi_flash_pkg::*;
#(
    parameter logic [7:0] base_addr = 8'h70
) (
    input  logic     ck,
    input  logic     rst_n,
    input  bus_req_t bus_req,
    output logic     sel,
    output logic     ack
);

    logic match;
    logic pending;

    assign match = bus_req.adr[31:24] == base_addr;

    // One pulse per claimed cycle.
    assign sel = bus_req.cyc && match && !pending;

    // Pending holds off a second ack while the host keeps cyc up.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= bus_req.cyc && (pending || sel);  // Cleared once cyc drops.
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= sel;
        end
    end

endmodule

// File: hdl/spi_flash_pkg.sv
package spi_flash_pkg;

    // Register word offsets, bus address bits 3:2.
    localparam logic [1:0] reg_cmd_off  = 2'd0;
    localparam logic [1:0] reg_addr_off = 2'd1;

    // Phase lengths of one SPI transaction, in bits.
    localparam int op_bits   = 8;
    localparam int addr_bits = 24;
    localparam int data_bits = 32;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic        cyc;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdt;
        logic        ack;
    } bus_rsp_t;

    // Command register, loaded from bus data bits 10:0.
    typedef struct packed {
        logic       no_read;    // Skip the 32-bit read phase.
        logic       incr_addr;  // Address += 4 after issue.
        logic       tx_addr;    // Send the 24-bit address.
        logic [7:0] code;
    } spi_cmd_t;

    typedef struct packed {
        logic cs;
        logic sck;
        logic mosi;
    } spi_pins_t;

endpackage
